/* rtl/stepper_pkg.sv */
`default_nettype none

package stepper_pkg;

  localparam int frame_bits = 32;
  localparam int arg_bits = frame_bits - 8;
  localparam int steps_bits = 16;
  localparam int angle_bits = 8;         // 256 positions per electrical cycle
  localparam int max_microsteps = 6;
  localparam int count_bits = 32;

  typedef enum logic [7:0] {
    op_config = 8'd1,
    op_period = 8'd2,
    op_enable = 8'd3,
    op_move   = 8'd4
  } opcode_t;

  typedef struct packed {
    logic [2:0]            microsteps;
    logic [7:0]            current;
    logic [steps_bits-1:0] step_period;
    logic                  enable;
  } drive_config_t;

  localparam drive_config_t cfg_reset = '{
    microsteps:  3'd0,
    current:     8'd128,
    step_period: 16'd1000,
    enable:      1'b0
  };

  // Quarter wave of cosine, 0 to 84.4 degrees
  localparam logic [7:0] cos_table [16] = '{
    8'd255, 8'd254, 8'd250, 8'd244, 8'd236, 8'd225, 8'd212, 8'd197,
    8'd180, 8'd162, 8'd142, 8'd120, 8'd98,  8'd74,  8'd50,  8'd25
  };

endpackage

`default_nettype wire

/* rtl/stepper_ifs.sv */
`timescale 1ns/10ps
`default_nettype none

// Frame receiver to command decoder
interface command_if import stepper_pkg::*; ();
  logic                         frame_valid;
  opcode_t                      opcode;
  logic [arg_bits-1:0]          argument;
  logic signed [count_bits-1:0] readback;  // Encoder count for CIPO

  modport rx  (output frame_valid, opcode, argument, input readback);
  modport dec (input frame_valid, opcode, argument);
endinterface

// Move buffer to step generator
interface move_if import stepper_pkg::*; ();
  logic                  move_valid;
  logic                  move_dir;
  logic [steps_bits-1:0] move_steps;
  logic                  move_take;

  modport src (output move_valid, move_dir, move_steps, input move_take);
  modport gen (input move_valid, move_dir, move_steps, output move_take);
endinterface

`default_nettype wire

/* rtl/spi_frame_receiver.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_frame_receiver import stepper_pkg::*; (
  input  logic  CLK,
  input  logic  resetn,
  input  logic  sck,
  input  logic  cs,
  input  logic  copi,
  output logic  cipo,
  command_if.rx cmd
);

  logic [2:0]            sck_sync;  // Two sync stages, then history
  logic [2:0]            cs_sync;
  logic [1:0]            copi_sync;
  logic                  sck_rise;
  logic                  sck_fall;
  logic                  cs_rise;
  logic                  cs_fall;
  logic [5:0]            bit_cnt;
  logic [frame_bits-1:0] rx_shift;
  logic [count_bits-1:0] tx_shift;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_sync  <= '0;
      cs_sync   <= '1;  // CS idles high
      copi_sync <= '0;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      cs_sync   <= {cs_sync[1:0], cs};
      copi_sync <= {copi_sync[0], copi};
    end
  end

  assign sck_rise = sck_sync[1] & ~sck_sync[2];
  assign sck_fall = ~sck_sync[1] & sck_sync[2];
  assign cs_rise  = cs_sync[1] & ~cs_sync[2];
  assign cs_fall  = ~cs_sync[1] & cs_sync[2];

  // Bit counter saturates so that long frames never alias to 32
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_cnt <= '0;
    end else if (cs_fall) begin
      bit_cnt <= '0;
    end else if (sck_rise && !cs_sync[1] && bit_cnt != '1) begin
      bit_cnt <= bit_cnt + 6'd1;
    end
  end

  always_ff @(posedge CLK) begin
    if (sck_rise && !cs_sync[1]) begin
      rx_shift <= {rx_shift[frame_bits-2:0], copi_sync[1]};  // MSB first
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      cmd.frame_valid <= 1'b0;
    end else begin
      cmd.frame_valid <= cs_rise && (bit_cnt == 6'(frame_bits));
    end
  end

  always_ff @(posedge CLK) begin
    if (cs_rise) begin
      cmd.opcode   <= opcode_t'(rx_shift[frame_bits-1:arg_bits]);
      cmd.argument <= rx_shift[arg_bits-1:0];
    end
  end

  // Readback snapshot on CS fall, next bit on each SCK fall
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      tx_shift <= '0;
    end else if (cs_fall) begin
      tx_shift <= cmd.readback;
    end else if (sck_fall && !cs_sync[1]) begin
      tx_shift <= {tx_shift[count_bits-2:0], 1'b0};
    end
  end

  assign cipo = tx_shift[count_bits-1];

  a_single_strobe: assert property (@(posedge CLK) disable iff (!resetn)
    cmd.frame_valid |=> !cmd.frame_valid);

endmodule

`default_nettype wire

/* rtl/command_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module command_decoder import stepper_pkg::*; (
  input  logic          CLK,
  input  logic          resetn,
  command_if.dec        cmd,
  move_if.src           mv,
  output drive_config_t cfg,
  output logic          buffer_dtr
);

  logic [2:0] microsteps_arg;
  logic       is_move;

  // Codes above the finest resolution fall back to it
  assign microsteps_arg = (cmd.argument[2:0] > 3'(max_microsteps)) ?
                          3'(max_microsteps) : cmd.argument[2:0];

  assign is_move = cmd.frame_valid && (cmd.opcode == op_move);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      cfg           <= cfg_reset;
      mv.move_valid <= 1'b0;
    end else begin
      if (mv.move_take) begin
        mv.move_valid <= 1'b0;
      end
      if (cmd.frame_valid) begin
        case (cmd.opcode)
          op_config: begin
            cfg.microsteps <= microsteps_arg;
            cfg.current    <= cmd.argument[15:8];
          end
          op_period: cfg.step_period <= cmd.argument[steps_bits-1:0];
          op_enable: cfg.enable      <= cmd.argument[0];
          op_move:   mv.move_valid   <= 1'b1;  // Overwrites a pending move
          default:   ;
        endcase
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (is_move) begin
      mv.move_dir   <= cmd.argument[16];
      mv.move_steps <= cmd.argument[steps_bits-1:0];
    end
  end

  assign buffer_dtr = ~mv.move_valid;

  // Generator must only take what is offered
  a_take_needs_valid: assert property (@(posedge CLK) disable iff (!resetn)
    mv.move_take |-> mv.move_valid);

endmodule

`default_nettype wire

/* rtl/step_generator.sv */
`timescale 1ns/10ps
`default_nettype none

module step_generator import stepper_pkg::*; (
  input  logic          CLK,
  input  logic          resetn,
  move_if.gen           mv,
  input  drive_config_t cfg,
  output logic          step,
  output logic          dir,
  output logic          move_done
);

  logic                  busy;
  logic [steps_bits-1:0] steps_left;
  logic [steps_bits-1:0] timer;
  logic [steps_bits-1:0] reload;

  // A period of zero behaves like one
  assign reload = (cfg.step_period > 1) ? cfg.step_period - 1'b1 : '0;

  assign mv.move_take = ~busy & cfg.enable & mv.move_valid;
  assign move_done    = ~busy;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      busy <= 1'b0;
      step <= 1'b0;
      dir  <= 1'b0;
    end else begin
      step <= 1'b0;
      if (!cfg.enable) begin
        busy <= 1'b0;  // Abort
      end else if (mv.move_take) begin
        dir  <= mv.move_dir;
        busy <= (mv.move_steps != '0);  // Empty move ends here
      end else if (busy && timer == '0) begin
        step <= 1'b1;
        if (steps_left == 1) begin
          busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (mv.move_take) begin
      steps_left <= mv.move_steps;
      timer      <= reload;
    end else if (busy) begin
      if (timer == '0) begin
        steps_left <= steps_left - 1'b1;
        timer      <= reload;
      end else begin
        timer <= timer - 1'b1;
      end
    end
  end

  // Remaining count never underflows during a move
  a_steps_left: assert property (@(posedge CLK) disable iff (!resetn)
    busy |-> steps_left != '0);

endmodule

`default_nettype wire

/* rtl/microstep_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module microstep_sequencer import stepper_pkg::*; (
  input  logic          CLK,
  input  logic          resetn,
  input  logic          step,
  input  logic          dir,
  input  drive_config_t cfg,
  output logic          phase_a1,
  output logic          phase_a2,
  output logic          phase_b1,
  output logic          phase_b2,
  output logic          vref_a,
  output logic          vref_b
);

  logic [angle_bits-1:0] angle;
  logic [angle_bits-1:0] incr;
  logic [1:0]            quadrant;
  logic [3:0]            idx_cos;
  logic [3:0]            idx_sin;
  logic [15:0]           prod_a;
  logic [15:0]           prod_b;
  logic [7:0]            pwm_cnt;
  logic                  a_pos;
  logic                  b_pos;

  assign incr = 8'd64 >> cfg.microsteps;  // Full step is a quarter cycle

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      angle <= '0;
    end else if (step) begin
      angle <= dir ? angle + incr : angle - incr;
    end
  end

  assign quadrant = angle[angle_bits-1 -: 2];
  assign a_pos    = (quadrant == 2'd0) || (quadrant == 2'd3);
  assign b_pos    = ~quadrant[1];

  // Odd quadrants run the table backwards
  assign idx_cos = quadrant[0] ? ~angle[5:2] : angle[5:2];
  assign idx_sin = ~idx_cos;
  assign prod_a  = cfg.current * cos_table[idx_cos];
  assign prod_b  = cfg.current * cos_table[idx_sin];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      pwm_cnt  <= '0;
      phase_a1 <= 1'b0;
      phase_a2 <= 1'b0;
      phase_b1 <= 1'b0;
      phase_b2 <= 1'b0;
      vref_a   <= 1'b0;
      vref_b   <= 1'b0;
    end else begin
      pwm_cnt  <= pwm_cnt + 8'd1;
      phase_a1 <= cfg.enable & a_pos;
      phase_a2 <= cfg.enable & ~a_pos;
      phase_b1 <= cfg.enable & b_pos;
      phase_b2 <= cfg.enable & ~b_pos;
      vref_a   <= cfg.enable & (pwm_cnt < prod_a[15:8]);  // Duty is current * mag / 256
      vref_b   <= cfg.enable & (pwm_cnt < prod_b[15:8]);
    end
  end

endmodule

`default_nettype wire

/* rtl/quadrature_counter.sv */
`timescale 1ns/10ps
`default_nettype none

module quadrature_counter import stepper_pkg::*; (
  input  logic                         CLK,
  input  logic                         resetn,
  input  logic                         enc_a,
  input  logic                         enc_b,
  output logic signed [count_bits-1:0] count,
  output logic                         fault
);

  logic [2:0] a_sync;
  logic [2:0] b_sync;
  logic [3:0] trans;  // Previous AB, then current AB

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      a_sync <= '0;
      b_sync <= '0;
    end else begin
      a_sync <= {a_sync[1:0], enc_a};
      b_sync <= {b_sync[1:0], enc_b};
    end
  end

  assign trans = {a_sync[2], b_sync[2], a_sync[1], b_sync[1]};

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      count <= '0;
      fault <= 1'b0;
    end else begin
      case (trans)
        // Forward Gray sequence 00 01 11 10
        4'b0001,
        4'b0111,
        4'b1110,
        4'b1000: count <= count + 1;
        4'b0100,
        4'b1101,
        4'b1011,
        4'b0010: count <= count - 1;
        // Both inputs moved in one sample
        4'b0011,
        4'b1100,
        4'b0110,
        4'b1001: fault <= 1'b1;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/stepper_core.sv */
`timescale 1ns/10ps
`default_nettype none

module stepper_core import stepper_pkg::*; (
  input  logic CLK,
  input  logic resetn,
  input  logic SCK,
  input  logic CS,
  input  logic COPI,
  output logic CIPO,
  input  logic ENC_A,
  input  logic ENC_B,
  output logic PHASE_A1,
  output logic PHASE_A2,
  output logic PHASE_B1,
  output logic PHASE_B2,
  output logic VREF_A,
  output logic VREF_B,
  output logic BUFFER_DTR,
  output logic MOVE_DONE,
  output logic ENC_FAULT
);

  command_if cmd_bus ();
  move_if    move_bus ();

  drive_config_t                cfg;
  logic                         step;
  logic                         dir;
  logic signed [count_bits-1:0] enc_count;

  assign cmd_bus.readback = enc_count;  // Count back out over SPI

  spi_frame_receiver spi_frame_receiver_i (
    .CLK    (CLK),
    .resetn (resetn),
    .sck    (SCK),
    .cs     (CS),
    .copi   (COPI),
    .cipo   (CIPO),
    .cmd    (cmd_bus.rx)
  );

  command_decoder command_decoder_i (
    .CLK        (CLK),
    .resetn     (resetn),
    .cmd        (cmd_bus.dec),
    .mv         (move_bus.src),
    .cfg        (cfg),
    .buffer_dtr (BUFFER_DTR)
  );

  step_generator step_generator_i (
    .CLK       (CLK),
    .resetn    (resetn),
    .mv        (move_bus.gen),
    .cfg       (cfg),
    .step      (step),
    .dir       (dir),
    .move_done (MOVE_DONE)
  );

  microstep_sequencer microstep_sequencer_i (
    .CLK      (CLK),
    .resetn   (resetn),
    .step     (step),
    .dir      (dir),
    .cfg      (cfg),
    .phase_a1 (PHASE_A1),
    .phase_a2 (PHASE_A2),
    .phase_b1 (PHASE_B1),
    .phase_b2 (PHASE_B2),
    .vref_a   (VREF_A),
    .vref_b   (VREF_B)
  );

  quadrature_counter quadrature_counter_i (
    .CLK    (CLK),
    .resetn (resetn),
    .enc_a  (ENC_A),
    .enc_b  (ENC_B),
    .count  (enc_count),
    .fault  (ENC_FAULT)
  );

endmodule

`default_nettype wire

/* bench/stepper_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module stepper_core_tb import stepper_pkg::*; ();

  localparam int wait_limit = 200000;  // Cycles before any wait gives up

  logic         CLK;
  logic         resetn;
  logic         SCK;
  logic         CS;
  logic         COPI;
  logic         ENC_A;
  logic         ENC_B;
  logic         CIPO;
  logic         PHASE_A1;
  logic         PHASE_A2;
  logic         PHASE_B1;
  logic         PHASE_B2;
  logic         VREF_A;
  logic         VREF_B;
  logic         BUFFER_DTR;
  logic         MOVE_DONE;
  logic         ENC_FAULT;
  wire  [3:0]   phases = {PHASE_A1, PHASE_A2, PHASE_B1, PHASE_B2};

  // Reference model of the drive
  logic         model_en = 1'b0;
  logic [2:0]   model_ms = 3'd0;
  logic [7:0]   angle_model = 8'd0;
  logic         pending_valid = 1'b0;
  logic [23:0]  pending_arg;
  int           enc_model = 0;
  logic [1:0]   enc_pos = 2'd0;     // Position in the Gray cycle
  int           changes = 0;        // Phase word changes since last check
  logic [3:0]   last_phases = 4'd0;
  logic [31:0]  reply;
  integer       seed = 14;
  logic [63:0]  kind;
  logic [1023:0] line;
  logic [31:0]  arg;
  logic [31:0]  expected;

  stepper_core stepper_core_i (
    .CLK        (CLK),
    .resetn     (resetn),
    .SCK        (SCK),
    .CS         (CS),
    .COPI       (COPI),
    .CIPO       (CIPO),
    .ENC_A      (ENC_A),
    .ENC_B      (ENC_B),
    .PHASE_A1   (PHASE_A1),
    .PHASE_A2   (PHASE_A2),
    .PHASE_B1   (PHASE_B1),
    .PHASE_B2   (PHASE_B2),
    .VREF_A     (VREF_A),
    .VREF_B     (VREF_B),
    .BUFFER_DTR (BUFFER_DTR),
    .MOVE_DONE  (MOVE_DONE),
    .ENC_FAULT  (ENC_FAULT)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // Quadrant changes seen on the phase pins
  always @(negedge CLK) begin
    if (phases != last_phases)
      changes = changes + 1;
    last_phases = phases;
  end

  task automatic tick();
    @(posedge CLK);
    #1;
  endtask

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] want, input string what);
    if (got !== want)
      stop_on_error($sformatf("mismatch at %0t ns: %s is %0h, expected %0h",
                              $time, what, got, want));
  endtask

  // A is positive in quadrants 0 and 3 and B in quadrants 0 and 1
  function automatic logic [3:0] phases_for(input logic [7:0] ang, input logic en);
    logic a_pos;
    logic b_pos;
    a_pos = (ang[7:6] == 2'd0) || (ang[7:6] == 2'd3);
    b_pos = (ang[7:6] < 2'd2);
    return en ? {a_pos, ~a_pos, b_pos, ~b_pos} : 4'b0000;
  endfunction

  task automatic apply_move(input logic [23:0] mv_arg);
    logic [7:0] delta;
    delta = 8'(mv_arg[15:0] * (64 >> model_ms));
    angle_model = mv_arg[16] ? angle_model + delta : angle_model - delta;
  endtask

  // SCK runs at CLK / 8 and COPI changes while SCK is low
  task automatic spi_frame(input logic [31:0] word, output logic [31:0] rdata);
    int i;
    CS = 1'b0;
    repeat (4) tick();
    for (i = 31; i >= 0; i--) begin
      COPI = word[i];
      repeat (4) tick();
      rdata[i] = CIPO;
      SCK = 1'b1;
      repeat (4) tick();
      SCK = 1'b0;
    end
    repeat (4) tick();
    CS = 1'b1;
    repeat (8) tick();  // Sync, strobe and register update
  endtask

  task automatic encoder_step(input logic up);
    enc_pos = up ? enc_pos + 2'd1 : enc_pos - 2'd1;
    enc_model = up ? enc_model + 1 : enc_model - 1;
    {ENC_A, ENC_B} = {enc_pos[1], enc_pos[1] ^ enc_pos[0]};
    repeat (4) tick();
  endtask

  task automatic wait_move_finished();
    int n;
    n = 0;
    while (!BUFFER_DTR) begin
      tick();
      n++;
      if (n > wait_limit)
        stop_on_error("timeout: BUFFER_DTR never went high again");
    end
    n = 0;
    while (!MOVE_DONE) begin
      tick();
      n++;
      if (n > wait_limit)
        stop_on_error("timeout: MOVE_DONE never went high");
    end
    repeat (4) tick();  // Last step reaches the phase pins
  endtask

  task automatic run_record(input logic [63:0] rkind, input logic [31:0] rarg,
                            input logic [31:0] rexp);
    int r;
    case (rkind)
      "cfg": begin
        spi_frame({op_config, rarg[23:0]}, reply);
        model_ms = (rarg[2:0] > max_microsteps) ? 3'(max_microsteps) : rarg[2:0];
      end
      "per": spi_frame({op_period, rarg[23:0]}, reply);
      "ena": begin
        spi_frame({op_enable, rarg[23:0]}, reply);
        model_en = rarg[0];
        if (model_en && pending_valid) begin
          apply_move(pending_arg);  // Buffered move starts on enable
          pending_valid = 1'b0;
        end
        changes = 0;
      end
      "queue": begin
        spi_frame({op_move, rarg[23:0]}, reply);
        if (model_en) begin
          apply_move(rarg[23:0]);
        end else begin
          pending_valid = 1'b1;  // Later move frames overwrite it
          pending_arg = rarg[23:0];
        end
        check(BUFFER_DTR, rexp, "BUFFER_DTR after move frame");
      end
      "wait": begin
        wait_move_finished();
        check(changes, rexp, "quadrant changes during move");
        check(phases, phases_for(angle_model, model_en), "phase outputs after move");
        changes = 0;
      end
      "hold": begin
        repeat (rarg) begin
          tick();
          check(MOVE_DONE, rexp, "MOVE_DONE while holding");
          check(phases, phases_for(angle_model, model_en), "phase outputs while holding");
          if (!model_en)
            check({VREF_A, VREF_B}, 2'b00, "VREF outputs while disabled");
        end
      end
      "enc": begin
        repeat (rarg) begin
          r = $random(seed);
          encoder_step(r[0]);
        end
        check(ENC_FAULT, rexp, "ENC_FAULT after Gray steps");
      end
      "glitch": begin
        enc_pos = enc_pos + 2'd2;  // Both A and B flip together
        {ENC_A, ENC_B} = {enc_pos[1], enc_pos[1] ^ enc_pos[0]};
        repeat (4) tick();
        check(ENC_FAULT, rexp, "ENC_FAULT after double change");
      end
      "read": begin
        spi_frame(32'h0, reply);  // Opcode 0 is ignored by the decoder
        check(reply, enc_model, "encoder count on CIPO");
        check(ENC_FAULT, rexp, "ENC_FAULT at readback");
      end
      default: stop_on_error($sformatf("unknown record kind %0s in input file", rkind));
    endcase
  endtask

  initial begin : main
    int fd;
    int r;
    int records;
    resetn = 1'b0;
    SCK = 1'b0;
    CS = 1'b1;
    COPI = 1'b0;
    ENC_A = 1'b0;
    ENC_B = 1'b0;
    records = 0;
    repeat (16) tick();
    resetn = 1'b1;
    repeat (2) tick();
    fd = $fopen("bench/stepper_input.txt", "r");
    if (fd == 0)
      stop_on_error("could not open bench/stepper_input.txt");
    while ($fscanf(fd, "%s", kind) == 1) begin
      if (kind == "#") begin
        r = $fgets(line, fd);  // Rest of a comment line
      end else begin
        r = $fscanf(fd, "%h %h", arg, expected);
        if (r != 2)
          stop_on_error("malformed record in bench/stepper_input.txt");
        run_record(kind, arg, expected);
        records++;
      end
    end
    $fclose(fd);
    if (records == 0) begin
      stop_on_error("no records found in bench/stepper_input.txt");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* bench/stepper_input.txt */
# kind argument expected, both numbers in hex
# expected is BUFFER_DTR for queue, quadrant changes for wait, MOVE_DONE for hold, ENC_FAULT else
hold   10     1
per    14     0
ena    1      0
queue  10003  1
wait   0      3
queue  2      1
wait   0      2
cfg    8002   0
queue  10004  1
wait   0      1
queue  10008  1
wait   0      2
queue  4      1
wait   0      1
per    c8     0
queue  10008  1
queue  10004  0
wait   0      3
ena    0      0
hold   40     1
queue  10005  0
hold   40     1
queue  0      0
ena    1      0
hold   10     1
enc    30     0
read   0      0
glitch 0      1
enc    8      1
read   0      1

/* verilog.f */
rtl/stepper_pkg.sv
rtl/stepper_ifs.sv
rtl/spi_frame_receiver.sv
rtl/command_decoder.sv
rtl/step_generator.sv
rtl/microstep_sequencer.sv
rtl/quadrature_counter.sv
rtl/stepper_core.sv
bench/stepper_core_tb.sv

/* Bender.yml */
package:
  name: stepper_core

sources:
  - files:
      - rtl/stepper_pkg.sv
      - rtl/stepper_ifs.sv
      - rtl/spi_frame_receiver.sv
      - rtl/command_decoder.sv
      - rtl/step_generator.sv
      - rtl/microstep_sequencer.sv
      - rtl/quadrature_counter.sv
      - rtl/stepper_core.sv
  - target: test
    files:
      - bench/stepper_core_tb.sv
